// File: hdl/cache_ctrl.sv
/* cache_ctrl: request capture, hit/miss decision, write-back, line fetch
   and processor response for the 8-way cache */
module cache_ctrl #(
    parameter int INDEX_W = 4,
    parameter int ADDR_W  = 25,
    localparam int TAG_W  = ADDR_W - cache_pkg::OFFSET_W - INDEX_W,
    localparam int LA_W   = ADDR_W - cache_pkg::OFFSET_W
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [ADDR_W-1:0]                   i_p_addr,
    input  logic [cache_pkg::BYTES_PER_WORD-1:0] i_p_byte_en,
    input  cache_pkg::word_t                    i_p_writedata,
    input  logic                                i_p_read,
    input  logic                                i_p_write,
    output cache_pkg::word_t                    o_p_readdata,
    output logic                                o_p_readdata_valid,
    output logic                                o_p_waitrequest,
    output logic [LA_W-1:0]                     o_m_addr,
    output cache_pkg::line_t                    o_m_writedata,
    output logic                                o_m_read,
    output logic                                o_m_write,
    input  cache_pkg::line_t                    i_m_readdata,
    input  logic                                i_m_readdata_valid,
    input  logic                                i_m_waitrequest,
    input  cache_pkg::way_mask_t                i_hit,
    input  cache_pkg::line_t                    i_hit_line,
    input  cache_pkg::way_mask_t                i_valid,
    input  cache_pkg::way_idx_t                 i_victim,
    input  logic                                i_victim_dirty,
    input  cache_pkg::line_t                    i_victim_line,
    input  logic [LA_W-1:0]                     i_victim_addr,
    output logic [INDEX_W-1:0]                  o_index,
    output logic [TAG_W-1:0]                    o_tag,
    output cache_pkg::way_mask_t                o_way_write,
    output logic [cache_pkg::WORDS_PER_LINE-1:0] o_word_en,
    output logic [cache_pkg::BYTES_PER_WORD-1:0] o_byte_en,
    output cache_pkg::line_t                    o_wr_line,
    output logic                                o_mark_clean,
    output logic                                o_plru_update,
    output cache_pkg::way_idx_t                 o_plru_way
);

    cache_pkg::ctrl_state_e                 state;
    logic [ADDR_W-1:0]                      addr_q;
    logic [ADDR_W-1:0]                      req_addr;
    logic [cache_pkg::BYTES_PER_WORD-1:0]   be_q;
    cache_pkg::word_t                       wdata_q;
    logic                                   read_q;
    cache_pkg::way_idx_t                    way_q;
    cache_pkg::way_idx_t                    way_sel;
    logic [cache_pkg::OFFSET_W-1:0]         offset;
    logic [cache_pkg::WORDS_PER_LINE-1:0]   word_sel;
    logic                                   hit_any;
    logic                                   need_wb;
    logic                                   in_fetch;

    assign hit_any  = |i_hit;
    assign need_wb  = !hit_any && (&i_valid) && i_victim_dirty;
    assign offset   = addr_q[cache_pkg::OFFSET_W-1:0];
    assign in_fetch = (state == cache_pkg::ST_FETCH_WAIT);

    // hit way, else lowest invalid way, else plru victim
    always_comb begin
        way_sel = i_victim;
        for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!i_valid[w]) way_sel = cache_pkg::way_idx_t'(w);
        end
        for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
            if (i_hit[w]) way_sel = cache_pkg::way_idx_t'(w);
        end
    end

    assign o_p_waitrequest = (state != cache_pkg::ST_IDLE);
    assign req_addr        = o_p_waitrequest ? addr_q : i_p_addr;  // live address while idle
    assign o_index         = req_addr[cache_pkg::OFFSET_W +: INDEX_W];
    assign o_tag           = req_addr[ADDR_W-1 -: TAG_W];
    assign o_plru_update   = (state == cache_pkg::ST_COMP);
    assign o_plru_way      = way_sel;
    assign o_mark_clean    = read_q;

    always_comb begin
        word_sel         = '0;
        word_sel[offset] = 1'b1;
        o_word_en        = in_fetch ? '1 : word_sel;
        o_byte_en        = in_fetch ? '1 : be_q;
        o_wr_line        = in_fetch ? i_m_readdata : {cache_pkg::WORDS_PER_LINE{wdata_q}};
        case (state)
            cache_pkg::ST_COMP:        o_way_write = read_q ? '0 : i_hit;  // write hit
            cache_pkg::ST_FETCH_WAIT:  o_way_write = i_m_readdata_valid ?
                                                     cache_pkg::way_mask_t'(1) << way_q : '0;
            cache_pkg::ST_FETCH_MERGE: o_way_write = cache_pkg::way_mask_t'(1) << way_q;
            default:                   o_way_write = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= cache_pkg::ST_IDLE;
            o_p_readdata_valid <= 1'b0;
            o_m_read           <= 1'b0;
            o_m_write          <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            case (state)
                cache_pkg::ST_IDLE: begin
                    if (i_p_read || i_p_write) state <= cache_pkg::ST_COMP;
                end
                cache_pkg::ST_COMP: begin
                    if (hit_any && read_q) begin
                        o_p_readdata_valid <= 1'b1;
                        state              <= cache_pkg::ST_IDLE;
                    end else if (hit_any) begin
                        state <= cache_pkg::ST_HIT;
                    end else if (need_wb) begin
                        state <= cache_pkg::ST_WB_LOAD;
                    end else begin
                        o_m_read <= 1'b1;
                        state    <= cache_pkg::ST_FETCH_REQ;
                    end
                end
                cache_pkg::ST_HIT: state <= cache_pkg::ST_IDLE;
                cache_pkg::ST_FETCH_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_read <= 1'b0;
                        state    <= cache_pkg::ST_FETCH_WAIT;
                    end
                end
                cache_pkg::ST_FETCH_WAIT: begin
                    if (i_m_readdata_valid && read_q) begin
                        o_p_readdata_valid <= 1'b1;
                        state              <= cache_pkg::ST_IDLE;
                    end else if (i_m_readdata_valid) begin
                        state <= cache_pkg::ST_FETCH_MERGE;
                    end
                end
                cache_pkg::ST_FETCH_MERGE: state <= cache_pkg::ST_IDLE;
                cache_pkg::ST_WB_LOAD: begin
                    o_m_write <= 1'b1;
                    state     <= cache_pkg::ST_WB_REQ;
                end
                cache_pkg::ST_WB_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_write <= 1'b0;
                        o_m_read  <= 1'b1;   // fetch follows straight on
                        state     <= cache_pkg::ST_FETCH_REQ;
                    end
                end
                default: state <= cache_pkg::ST_IDLE;
            endcase
        end
    end

    // request and bus payload
    always_ff @(posedge clk) begin
        if (state == cache_pkg::ST_IDLE) begin
            addr_q  <= i_p_addr;
            be_q    <= i_p_byte_en;
            wdata_q <= i_p_writedata;
            read_q  <= i_p_read;     // read wins over write
        end
        if (state == cache_pkg::ST_COMP) begin
            way_q        <= way_sel;
            o_p_readdata <= i_hit_line[offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];
            o_m_addr     <= addr_q[ADDR_W-1:cache_pkg::OFFSET_W];
        end
        if (in_fetch) begin
            o_p_readdata <= i_m_readdata[offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        end
        if (state == cache_pkg::ST_WB_LOAD) begin
            o_m_addr      <= i_victim_addr;   // victim still valid from plru read
            o_m_writedata <= i_victim_line;
        end
        if (state == cache_pkg::ST_WB_REQ && !i_m_waitrequest) begin
            o_m_addr <= addr_q[ADDR_W-1:cache_pkg::OFFSET_W];
        end
    end

endmodule

// File: hdl/cache_pkg.sv
/* cache_pkg: geometry, data types and controller states shared by the
   8-way write-back cache */
package cache_pkg;

    localparam int WAYS           = 8;
    localparam int WAY_IDX_W      = 3;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 2;   // word offset inside a line
    localparam int WORD_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int LINE_W         = 128;
    localparam int PLRU_W         = 7;   // tree bits per set

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [WAYS-1:0]      way_mask_t;
    typedef logic [WAY_IDX_W-1:0] way_idx_t;

    // controller FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMP,          // tag compare, one cycle after accept
        ST_HIT,
        ST_FETCH_REQ,
        ST_FETCH_WAIT,
        ST_FETCH_MERGE,   // write miss, word merged into fetched line
        ST_WB_LOAD,
        ST_WB_REQ
    } ctrl_state_e;

endpackage

// File: hdl/cache_top.sv
/* cache_top: 8-way set-associative write-back cache, ways, pseudo-LRU
   and controller between a word processor port and a line memory port */
module cache_top #(
    parameter int INDEX_W = 4,
    parameter int ADDR_W  = 25,
    localparam int TAG_W  = ADDR_W - cache_pkg::OFFSET_W - INDEX_W,
    localparam int LA_W   = ADDR_W - cache_pkg::OFFSET_W
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [ADDR_W-1:0]                   i_p_addr,
    input  logic [cache_pkg::BYTES_PER_WORD-1:0] i_p_byte_en,
    input  cache_pkg::word_t                    i_p_writedata,
    input  logic                                i_p_read,
    input  logic                                i_p_write,
    output cache_pkg::word_t                    o_p_readdata,
    output logic                                o_p_readdata_valid,
    output logic                                o_p_waitrequest,
    output logic [LA_W-1:0]                     o_m_addr,
    output cache_pkg::line_t                    o_m_writedata,
    output logic                                o_m_read,
    output logic                                o_m_write,
    input  cache_pkg::line_t                    i_m_readdata,
    input  logic                                i_m_readdata_valid,
    input  logic                                i_m_waitrequest
);

    logic [INDEX_W-1:0]                         index;
    logic [TAG_W-1:0]                           tag;
    cache_pkg::way_mask_t                       way_write;
    logic [cache_pkg::WORDS_PER_LINE-1:0]       word_en;
    logic [cache_pkg::BYTES_PER_WORD-1:0]       byte_en;
    cache_pkg::line_t                           wr_line;
    logic                                       mark_clean;
    logic                                       plru_update;
    cache_pkg::way_idx_t                        plru_way;
    cache_pkg::way_idx_t                        victim;
    cache_pkg::way_mask_t                       hit;
    cache_pkg::way_mask_t                       valid;
    cache_pkg::way_mask_t                       dirty;
    cache_pkg::line_t [cache_pkg::WAYS-1:0]     rd_line;
    logic [cache_pkg::WAYS-1:0][TAG_W-1:0]      way_tag;
    cache_pkg::line_t                           hit_line;
    logic [LA_W-1:0]                            victim_addr;

    for (genvar w = 0; w < cache_pkg::WAYS; w++) begin : g_way
        cache_way #(
            .INDEX_W (INDEX_W),
            .ADDR_W  (ADDR_W)
        ) way_inst (
            .clk          (clk),
            .rst          (rst),
            .i_index      (index),
            .i_tag        (tag),
            .i_write      (way_write[w]),
            .i_word_en    (word_en),
            .i_byte_en    (byte_en),
            .i_wr_line    (wr_line),
            .i_mark_clean (mark_clean),
            .o_rd_line    (rd_line[w]),
            .o_tag        (way_tag[w]),
            .o_hit        (hit[w]),
            .o_valid      (valid[w]),
            .o_dirty      (dirty[w])
        );
    end

    // at most one way hits
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (hit[w]) hit_line = rd_line[w];
        end
    end

    assign victim_addr = {way_tag[victim], index};   // write-back line address

    plru_tree #(
        .INDEX_W (INDEX_W)
    ) plru_inst (
        .clk      (clk),
        .rst      (rst),
        .i_index  (index),
        .i_update (plru_update),
        .i_way    (plru_way),
        .o_victim (victim)
    );

    cache_ctrl #(
        .INDEX_W (INDEX_W),
        .ADDR_W  (ADDR_W)
    ) ctrl_inst (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (i_p_addr),
        .i_p_byte_en        (i_p_byte_en),
        .i_p_writedata      (i_p_writedata),
        .i_p_read           (i_p_read),
        .i_p_write          (i_p_write),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_addr           (o_m_addr),
        .o_m_writedata      (o_m_writedata),
        .o_m_read           (o_m_read),
        .o_m_write          (o_m_write),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .i_hit              (hit),
        .i_hit_line         (hit_line),
        .i_valid            (valid),
        .i_victim           (victim),
        .i_victim_dirty     (dirty[victim]),
        .i_victim_line      (rd_line[victim]),
        .i_victim_addr      (victim_addr),
        .o_index            (index),
        .o_tag              (tag),
        .o_way_write        (way_write),
        .o_word_en          (word_en),
        .o_byte_en          (byte_en),
        .o_wr_line          (wr_line),
        .o_mark_clean       (mark_clean),
        .o_plru_update      (plru_update),
        .o_plru_way         (plru_way)
    );

endmodule

// File: hdl/cache_way.sv
/* cache_way: one way of the cache, line data with byte write enables,
   tag storage, valid and dirty bits per set and the tag compare */
module cache_way #(
    parameter int INDEX_W = 4,
    parameter int ADDR_W  = 25,
    localparam int TAG_W  = ADDR_W - cache_pkg::OFFSET_W - INDEX_W
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [INDEX_W-1:0]                  i_index,
    input  logic [TAG_W-1:0]                    i_tag,
    input  logic                                i_write,
    input  logic [cache_pkg::WORDS_PER_LINE-1:0] i_word_en,
    input  logic [cache_pkg::BYTES_PER_WORD-1:0] i_byte_en,
    input  cache_pkg::line_t                    i_wr_line,
    input  logic                                i_mark_clean,
    output cache_pkg::line_t                    o_rd_line,
    output logic [TAG_W-1:0]                    o_tag,
    output logic                                o_hit,
    output logic                                o_valid,
    output logic                                o_dirty
);

    localparam int SETS = 2 ** INDEX_W;

    cache_pkg::line_t   data_mem [SETS];
    logic [TAG_W-1:0]   tag_mem  [SETS];
    logic [SETS-1:0]    valid_q;
    logic [SETS-1:0]    dirty_q;

    // data and tag arrays, registered read
    always_ff @(posedge clk) begin
        if (i_write) begin
            for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
                for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
                    if (i_word_en[w] && i_byte_en[b]) begin
                        data_mem[i_index][(w*cache_pkg::BYTES_PER_WORD+b)*8 +: 8] <=
                            i_wr_line[(w*cache_pkg::BYTES_PER_WORD+b)*8 +: 8];
                    end
                end
            end
            tag_mem[i_index] <= i_tag;
        end
        o_rd_line <= data_mem[i_index];
        o_tag     <= tag_mem[i_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            o_valid <= 1'b0;
            o_dirty <= 1'b0;
        end else begin
            if (i_write) begin
                valid_q[i_index] <= 1'b1;
                dirty_q[i_index] <= !i_mark_clean;  // read fill stays clean
            end
            o_valid <= valid_q[i_index];
            o_dirty <= dirty_q[i_index];
        end
    end

    assign o_hit = o_valid && (o_tag == i_tag);

endmodule

// File: hdl/plru_tree.sv
/* plru_tree: 7-bit tree pseudo-LRU per set, victim choice from the stored
   tree and path update on each access */
module plru_tree #(
    parameter int INDEX_W = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_W-1:0]    i_index,
    input  logic                  i_update,
    input  cache_pkg::way_idx_t   i_way,
    output cache_pkg::way_idx_t   o_victim
);

    localparam int SETS = 2 ** INDEX_W;

    // bit 6 root, bits 5/4 pair select for ways 0-3 / 4-7,
    // bits 3..0 leaves for pairs 0/1, 2/3, 4/5, 6/7
    logic [cache_pkg::PLRU_W-1:0] tree_q [SETS];
    logic [cache_pkg::PLRU_W-1:0] tree_rd;
    logic [cache_pkg::PLRU_W-1:0] tree_nxt;
    logic                         half;
    logic                         pair;
    logic [1:0]                   pair_idx;

    // victim walk
    always_comb begin
        half     = tree_rd[6];
        pair     = tree_rd[5 - half];
        pair_idx = {half, pair};
        o_victim = {half, pair, tree_rd[3 - pair_idx]};
    end

    // point every bit on the path away from the accessed way
    always_comb begin
        tree_nxt                = tree_rd;
        tree_nxt[6]             = !i_way[2];
        tree_nxt[5 - i_way[2]]  = !i_way[1];
        tree_nxt[3 - i_way[2:1]] = !i_way[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
            tree_rd <= '0;
        end else begin
            if (i_update) begin
                tree_q[i_index] <= tree_nxt;
            end
            tree_rd <= tree_q[i_index];   // old value on an update edge
        end
    end

endmodule

// File: project.f
hdl/cache_pkg.sv
hdl/cache_way.sv
hdl/plru_tree.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
testbench/mem_model.sv
testbench/cache_tb.sv

// File: run.sh
#!/bin/bash
# compile and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module cache_tb -f project.f -o cache_sim || exit 1
./obj_dir/cache_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

// File: testbench/cache_tb.sv
/* cache_tb: table-driven test of the 8-way write-back cache against a model
   of memory words, cache tags, dirty bits and pseudo-LRU trees */
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          INDEX_W    = 4;
    localparam int          ADDR_W     = 25;
    localparam int          TAG_W      = ADDR_W - cache_pkg::OFFSET_W - INDEX_W;
    localparam int          LA_W       = ADDR_W - cache_pkg::OFFSET_W;
    localparam int          SETS       = 2 ** INDEX_W;
    localparam int          N_OPS      = 19;
    localparam int          MAX_CYCLES = N_OPS * 40;
    localparam logic [31:0] FILL_KEY   = 32'h5a3c96e1;

    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [3:0]        be;
        logic              hit;   // expected hit
    } op_t;

    // set 3 takes nine tags, tag 1 is written first and leaves dirty
    op_t ops [N_OPS] = '{
        '{1'b0, 25'h000010, 4'hf, 1'b0},   // cold miss
        '{1'b0, 25'h000013, 4'hf, 1'b1},
        '{1'b1, 25'h000011, 4'h6, 1'b1},   // partial write hit
        '{1'b0, 25'h000011, 4'hf, 1'b1},
        '{1'b1, 25'h000025, 4'h9, 1'b0},   // partial write miss
        '{1'b0, 25'h000025, 4'hf, 1'b1},
        '{1'b1, 25'h00004c, 4'hf, 1'b0},
        '{1'b0, 25'h00008d, 4'hf, 1'b0},
        '{1'b0, 25'h0000ce, 4'hf, 1'b0},
        '{1'b0, 25'h00010f, 4'hf, 1'b0},
        '{1'b0, 25'h00014c, 4'hf, 1'b0},
        '{1'b0, 25'h00018d, 4'hf, 1'b0},
        '{1'b0, 25'h0001ce, 4'hf, 1'b0},
        '{1'b0, 25'h00020f, 4'hf, 1'b0},
        '{1'b0, 25'h00024c, 4'hf, 1'b0},   // ninth tag, dirty way 0 goes out
        '{1'b0, 25'h00004c, 4'hf, 1'b0},   // refetch of the written-back line
        '{1'b0, 25'h000013, 4'hf, 1'b1},
        '{1'b1, 25'h00024d, 4'h3, 1'b1},
        '{1'b0, 25'h00024d, 4'hf, 1'b1}
    };

    logic                 clk;
    logic                 rst;
    logic [ADDR_W-1:0]    p_addr;
    logic [3:0]           p_byte_en;
    cache_pkg::word_t     p_writedata;
    logic                 p_read;
    logic                 p_write;
    cache_pkg::word_t     p_readdata;
    logic                 p_readdata_valid;
    logic                 p_waitrequest;
    logic [LA_W-1:0]      m_addr;
    cache_pkg::line_t     m_writedata;
    logic                 m_read;
    logic                 m_write;
    cache_pkg::line_t     m_readdata;
    logic                 m_readdata_valid;
    logic                 m_waitrequest;

    logic [TAG_W-1:0]     m_tag    [SETS][cache_pkg::WAYS];
    logic                 m_valid  [SETS][cache_pkg::WAYS];
    logic                 m_dirty  [SETS][cache_pkg::WAYS];
    logic                 lru_root [SETS];
    logic [1:0]           lru_mid  [SETS];   // per half
    logic [3:0]           lru_leaf [SETS];   // per pair
    cache_pkg::word_t     shadow   [logic [ADDR_W-1:0]];
    logic [31:0]          rng;
    int                   errors;
    int                   checks;
    int                   cycles;

    cache_top #(
        .INDEX_W (INDEX_W),
        .ADDR_W  (ADDR_W)
    ) cache_top_inst (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (p_addr),
        .i_p_byte_en        (p_byte_en),
        .i_p_writedata      (p_writedata),
        .i_p_read           (p_read),
        .i_p_write          (p_write),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_m_addr           (m_addr),
        .o_m_writedata      (m_writedata),
        .o_m_read           (m_read),
        .o_m_write          (m_write),
        .i_m_readdata       (m_readdata),
        .i_m_readdata_valid (m_readdata_valid),
        .i_m_waitrequest    (m_waitrequest)
    );

    mem_model #(
        .LA_W (LA_W)
    ) mem_inst (
        .clk              (clk),
        .i_addr           (m_addr),
        .i_writedata      (m_writedata),
        .i_read           (m_read),
        .i_write          (m_write),
        .o_readdata       (m_readdata),
        .o_readdata_valid (m_readdata_valid),
        .o_waitrequest    (m_waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // line address * 4 + offset is just the word address
    function automatic cache_pkg::word_t mem_word(logic [ADDR_W-1:0] a);
        if (shadow.exists(a)) return shadow[a];
        return 32'(a) ^ FILL_KEY;
    endfunction

    function automatic int victim_of(int s);
        logic h;
        logic p;
        h = lru_root[s];
        p = lru_mid[s][h];
        return int'({h, p, lru_leaf[s][{h, p}]});
    endfunction

    // path bits point away from the accessed way
    function automatic void touch_lru(int s, int w);
        logic [2:0] wi;
        wi = 3'(w);
        lru_root[s]          = !wi[2];
        lru_mid[s][wi[2]]    = !wi[1];
        lru_leaf[s][wi[2:1]] = !wi[0];
    endfunction

    task automatic compare_value(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic run_op(input op_t op);
        logic [INDEX_W-1:0] set;
        logic [TAG_W-1:0]   tag;
        logic [LA_W-1:0]    wb_addr;
        cache_pkg::line_t   wb_line;
        cache_pkg::word_t   wdata;
        cache_pkg::word_t   old;
        cache_pkg::word_t   merged;
        logic               hit;
        logic               wb;
        logic               bus_seen;
        int                 way;
        int                 edges;
        int                 rd0;
        int                 wr0;

        set = op.addr[cache_pkg::OFFSET_W +: INDEX_W];
        tag = op.addr[ADDR_W-1 -: TAG_W];
        way = -1;
        for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
        end
        hit = (way >= 0);
        for (int w = cache_pkg::WAYS - 1; w >= 0 && !hit; w--) begin
            if (!m_valid[set][w]) way = w;   // lowest invalid fills first
        end
        if (way < 0) way = victim_of(set);
        wb      = !hit && m_dirty[set][way];
        wb_addr = {m_tag[set][way], set};
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            wb_line[w*32 +: 32] = mem_word({wb_addr, 2'(w)});
        end
        touch_lru(set, way);
        m_dirty[set][way] = op.wr || (hit && m_dirty[set][way]);
        m_valid[set][way] = 1'b1;
        m_tag[set][way]   = tag;

        rng    = xorshift(rng);
        wdata  = rng;
        old    = mem_word(op.addr);
        merged = old;
        for (int b = 0; b < cache_pkg::BYTES_PER_WORD; b++) begin
            if (op.be[b]) merged[b*8 +: 8] = wdata[b*8 +: 8];
        end
        rd0 = mem_inst.rd_count;
        wr0 = mem_inst.wr_count;

        p_addr      = op.addr;
        p_byte_en   = op.be;
        p_writedata = wdata;
        p_read      = !op.wr;
        p_write     = op.wr;
        @(posedge clk);   // cache idle, so accepted here
        #2;
        p_read   = 1'b0;
        p_write  = 1'b0;
        edges    = 0;
        bus_seen = 1'b0;
        while (op.wr ? p_waitrequest : !p_readdata_valid) begin
            @(posedge clk);
            #2;
            edges++;
            bus_seen = bus_seen || m_read || m_write;
        end

        if (op.hit) begin
            // read pulse shows after one edge, sampled on the second
            compare_value(op.wr ? "o_p_waitrequest cycles" : "o_p_readdata_valid edges",
                          edges, op.wr ? 2 : 1);
            compare_value("o_m_read/o_m_write on hit", bus_seen, 0);
        end else begin
            compare_value("o_m_read accepts", mem_inst.rd_count - rd0, 1);
            compare_value("o_m_addr of fetch", mem_inst.last_rd_addr, op.addr[ADDR_W-1:2]);
            compare_value("o_m_write accepts", mem_inst.wr_count - wr0, wb);
            if (wb) begin
                compare_value("o_m_addr of write-back", mem_inst.last_wr_addr, wb_addr);
                compare_value("o_m_writedata", mem_inst.last_wr_line, wb_line);
                compare_value("o_m_read after o_m_write", mem_inst.last_was_read, 1);
            end
        end
        if (op.wr) shadow[op.addr] = merged;
        else compare_value("o_p_readdata", p_readdata, old);
    endtask

    initial begin
        rst         = 1'b1;
        p_addr      = '0;
        p_byte_en   = '0;
        p_writedata = '0;
        p_read      = 1'b0;
        p_write     = 1'b0;
        errors      = 0;
        checks      = 0;
        rng         = 32'h7eaaafd4;
        for (int s = 0; s < SETS; s++) begin
            lru_root[s] = 1'b0;
            lru_mid[s]  = '0;
            lru_leaf[s] = '0;
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < N_OPS; i++) begin
            run_op(ops[i]);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the cache did not finish the table within %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: testbench/mem_model.sv
/* mem_model: line-wide backing memory for the cache with fixed wait states
   and read latency, keeping a record of accepted requests */
module mem_model #(
    parameter int LA_W = 23
) (
    input  logic             clk,
    input  logic [LA_W-1:0]  i_addr,
    input  cache_pkg::line_t i_writedata,
    input  logic             i_read,
    input  logic             i_write,
    output cache_pkg::line_t o_readdata,
    output logic             o_readdata_valid,
    output logic             o_waitrequest
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          WAIT_CYCLES = 2;
    localparam int          READ_LAT    = 3;
    localparam logic [31:0] FILL_KEY    = 32'h5a3c96e1;

    cache_pkg::line_t mem [logic [LA_W-1:0]];   // lines written so far
    int               wait_cnt;
    int               lat_cnt;
    logic [LA_W-1:0]  rd_addr;
    int               rd_count;
    int               wr_count;
    logic [LA_W-1:0]  last_rd_addr;
    logic [LA_W-1:0]  last_wr_addr;
    cache_pkg::line_t last_wr_line;
    logic             last_was_read;

    // untouched lines hold (line address * 4 + word) ^ FILL_KEY
    function automatic cache_pkg::line_t line_at(logic [LA_W-1:0] la);
        cache_pkg::line_t l;
        if (mem.exists(la)) return mem[la];
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            l[w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = (32'(la) * 4 + 32'(w)) ^ FILL_KEY;
        end
        return l;
    endfunction

    initial begin
        o_readdata       = '0;
        o_readdata_valid = 1'b0;
        o_waitrequest    = 1'b1;
        wait_cnt         = 0;
        lat_cnt          = 0;
        rd_count         = 0;
        wr_count         = 0;
        last_was_read    = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            o_readdata_valid = 1'b0;
            if (lat_cnt > 0) begin
                lat_cnt--;
                if (lat_cnt == 0) begin
                    o_readdata       = line_at(rd_addr);
                    o_readdata_valid = 1'b1;
                end
            end
            if ((i_read || i_write) && wait_cnt < WAIT_CYCLES) begin
                o_waitrequest = 1'b1;
                wait_cnt++;
            end else if (i_read || i_write) begin
                o_waitrequest = 1'b0;   // taken on the coming edge
                wait_cnt      = 0;
                if (i_write) begin
                    mem[i_addr]   = i_writedata;
                    wr_count++;
                    last_wr_addr  = i_addr;
                    last_wr_line  = i_writedata;
                    last_was_read = 1'b0;
                end else begin
                    rd_addr       = i_addr;
                    lat_cnt       = READ_LAT;
                    rd_count++;
                    last_rd_addr  = i_addr;
                    last_was_read = 1'b1;
                end
            end else begin
                o_waitrequest = 1'b1;
            end
        end
    end

endmodule
